// ==== common/busCycle_settings.svh ====
// bus widths, refresh counter width and register reset values
`ifndef BUSCYCLE_SETTINGS_SVH
`define BUSCYCLE_SETTINGS_SVH

`define ADDR_W 16 // address bus
`define DATA_W 8 // data bus
`define REFRESH_BITS 7 // low bits of R that count

`define PC_RESET 16'h0000 // first fetch address

`endif

// ==== common/busCyclePkg.sv ====
// cycle kind and T-state enums, address word union
`include "busCycle_settings.svh"

package busCyclePkg;

    typedef enum logic [2:0] {
        kFetch = 3'd0, // opcode fetch with refresh
        kMemRd = 3'd1,
        kMemWr = 3'd2,
        kIoRd  = 3'd3,
        kIoWr  = 3'd4
    } cycleKind_e;

    typedef enum logic [2:0] {
        sIdle = 3'd0,
        sT1   = 3'd1,
        sT2   = 3'd2,
        sTw   = 3'd3, // wait state, after T2
        sT3   = 3'd4,
        sT4   = 3'd5 // fetch only
    } tState_e;

    // refresh drives the two halves from different registers
    typedef union packed {
        logic [`ADDR_W-1:0] word;
        struct packed {
            logic [`ADDR_W/2-1:0] hi;
            logic [`ADDR_W/2-1:0] lo;
        } bytes;
    } addrWord_u;

endpackage

// ==== cycleDecoder/fetchDecode.sv ====
// opcode fetch and refresh strobe decode
`timescale 1ns/10ps

module fetchDecode (
    input  logic                 active_i,
    input  busCyclePkg::tState_e tState_i,
    output logic                 m1_o,
    output logic                 mreq_o,
    output logic                 rd_o,
    output logic                 rfsh_o,
    output logic                 selPc_o,
    output logic                 selRefresh_o,
    output logic                 capture_o,
    output logic                 incPc_o,
    output logic                 incR_o,
    output logic                 last_o
);
    import busCyclePkg::*;

    logic opHalf; // T1, T2 and waits
    logic rfshHalf; // T3 and T4
    logic sample;

    assign opHalf = active_i & (tState_i inside {sT1, sT2, sTw});
    assign rfshHalf = active_i & (tState_i inside {sT3, sT4});
    assign sample = active_i & (tState_i inside {sT2, sTw}); // last one wins

    assign m1_o = opHalf;
    assign mreq_o = opHalf | rfshHalf;
    assign rd_o = opHalf;
    assign rfsh_o = rfshHalf;
    assign selPc_o = opHalf;
    assign selRefresh_o = rfshHalf;
    assign capture_o = sample;
    assign incPc_o = active_i & (tState_i == sT4);
    assign incR_o = active_i & (tState_i == sT4);
    assign last_o = active_i & (tState_i == sT4);

endmodule

// ==== cycleDecoder/transferDecode.sv ====
// memory and I/O read/write strobe decode
`timescale 1ns/10ps

module transferDecode (
    input  logic                    active_i,
    input  busCyclePkg::cycleKind_e kind_i,
    input  busCyclePkg::tState_e    tState_i,
    output logic                    mreq_o,
    output logic                    iorq_o,
    output logic                    rd_o,
    output logic                    wr_o,
    output logic                    dataOe_o,
    output logic                    selReq_o,
    output logic                    capture_o,
    output logic                    autoWait_o,
    output logic                    last_o
);
    import busCyclePkg::*;

    logic isIo;
    logic isWr;
    logic inT1;
    logic inT2w; // T2 or any wait
    logic inT3;

    assign isIo = (kind_i inside {kIoRd, kIoWr});
    assign isWr = (kind_i inside {kMemWr, kIoWr});

    assign inT1 = active_i & (tState_i == sT1);
    assign inT2w = active_i & (tState_i inside {sT2, sTw});
    assign inT3 = active_i & (tState_i == sT3);

    always_comb begin
        if (isIo) begin
            mreq_o = 1'b0;
            iorq_o = inT2w | inT3;
            rd_o = ~isWr & (inT2w | inT3);
            wr_o = isWr & (inT2w | inT3);
        end else begin
            mreq_o = inT1 | inT2w | (isWr & inT3); // write holds through T3
            iorq_o = 1'b0;
            rd_o = ~isWr & (inT1 | inT2w);
            wr_o = isWr & inT2w;
        end
    end

    assign dataOe_o = isWr & (inT2w | inT3);
    assign selReq_o = inT1 | inT2w | inT3;
    assign capture_o = ~isWr & inT2w;
    assign autoWait_o = isIo & active_i & (tState_i == sT2);
    assign last_o = inT3;

endmodule

// ==== cycleDecoder/cycleDecoder.sv ====
// per-cycle decoder merge and wait-state control
`timescale 1ns/10ps

module cycleDecoder (
    input  logic                    clk_i,
    input  logic                    rstN_i,
    input  busCyclePkg::cycleKind_e curKind_i,
    input  busCyclePkg::tState_e    tState_i,
    input  logic                    waitN_i,
    output logic                    enterWait_o,
    output logic                    holdWait_o,
    output logic                    lastState_o,
    output logic                    selPc_o,
    output logic                    selRefresh_o,
    output logic                    selReq_o,
    output logic                    incPc_o,
    output logic                    incR_o,
    output logic                    m1_o,
    output logic                    mreq_o,
    output logic                    iorq_o,
    output logic                    rd_o,
    output logic                    wr_o,
    output logic                    rfsh_o,
    output logic                    dataOe_o,
    output logic                    capture_o
);
    import busCyclePkg::*;

    logic fetchEn;
    logic xferEn;
    logic mreqF;
    logic rdF;
    logic captureF;
    logic lastF;
    logic mreqX;
    logic rdX;
    logic captureX;
    logic lastX;
    logic autoWait;
    logic waitReq;
    logic waitOwed; // one more Tw due after the current one

    assign fetchEn = (curKind_i == kFetch);
    assign xferEn = ~fetchEn;

    fetchDecode fetch (
        .active_i(fetchEn),
        .tState_i(tState_i),
        .m1_o(m1_o),
        .mreq_o(mreqF),
        .rd_o(rdF),
        .rfsh_o(rfsh_o),
        .selPc_o(selPc_o),
        .selRefresh_o(selRefresh_o),
        .capture_o(captureF),
        .incPc_o(incPc_o),
        .incR_o(incR_o),
        .last_o(lastF)
    );

    transferDecode xfer (
        .active_i(xferEn),
        .kind_i(curKind_i),
        .tState_i(tState_i),
        .mreq_o(mreqX),
        .iorq_o(iorq_o),
        .rd_o(rdX),
        .wr_o(wr_o),
        .dataOe_o(dataOe_o),
        .selReq_o(selReq_o),
        .capture_o(captureX),
        .autoWait_o(autoWait),
        .last_o(lastX)
    );

    assign mreq_o = mreqF | mreqX;
    assign rd_o = rdF | rdX;
    assign capture_o = captureF | captureX;
    assign lastState_o = lastF | lastX;

    // I/O with waitN low in T2 owes a Tw beyond the automatic one
    assign waitReq = ~waitN_i;
    assign enterWait_o = (tState_i == sT2) & (waitReq | autoWait);
    assign holdWait_o = (tState_i == sTw) & (waitReq | waitOwed);

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            waitOwed <= 1'b0;
        end else if (tState_i == sT2) begin
            waitOwed <= waitReq & autoWait;
        end else if (tState_i == sTw) begin
            waitOwed <= waitReq & waitOwed;
        end else begin
            waitOwed <= 1'b0;
        end
    end

endmodule

// ==== src/tStateCounter.sv ====
// T-state register with wait stretch and return to idle
`timescale 1ns/10ps

module tStateCounter (
    input  logic                 clk_i,
    input  logic                 rstN_i,
    input  logic                 start_i,
    input  logic                 enterWait_i,
    input  logic                 holdWait_i,
    input  logic                 lastState_i,
    output busCyclePkg::tState_e tState_o
);
    import busCyclePkg::*;

    tState_e tState;
    tState_e tStateNext;

    always_comb begin
        tStateNext = tState;
        case (tState)
            sIdle: begin
                if (start_i) begin
                    tStateNext = sT1;
                end
            end
            sT1: tStateNext = sT2;
            sT2: tStateNext = enterWait_i ? sTw : sT3;
            sTw: tStateNext = holdWait_i ? sTw : sT3;
            sT3: tStateNext = lastState_i ? sIdle : sT4; // memory and I/O end here
            sT4: tStateNext = lastState_i ? sIdle : sT4;
            default: tStateNext = sIdle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            tState <= sIdle;
        end else begin
            tState <= tStateNext;
        end
    end

    assign tState_o = tState;

endmodule

// ==== src/cycleSequencer.sv ====
// request latch with busy and done generation
`timescale 1ns/10ps
`include "busCycle_settings.svh"

module cycleSequencer (
    input  logic                    clk_i,
    input  logic                    rstN_i,
    input  logic                    startStrobe_i,
    input  busCyclePkg::cycleKind_e cycleKind_i,
    input  logic [`ADDR_W-1:0]      reqAddr_i,
    input  logic [`DATA_W-1:0]      wrData_i,
    input  logic                    lastState_i,
    output logic                    start_o,
    output busCyclePkg::cycleKind_e curKind_o,
    output busCyclePkg::addrWord_u  latAddr_o,
    output logic [`DATA_W-1:0]      latData_o,
    output logic                    busy_o,
    output logic                    done_o
);
    import busCyclePkg::*;

    logic busyQ;
    logic doneQ;
    cycleKind_e curKindQ;
    addrWord_u latAddrQ;
    logic [`DATA_W-1:0] latDataQ;

    assign start_o = startStrobe_i & ~busyQ; // dropped while busy

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            busyQ <= 1'b0;
            doneQ <= 1'b0;
            curKindQ <= kFetch;
        end else begin
            doneQ <= lastState_i;
            if (lastState_i) begin
                busyQ <= 1'b0;
            end else if (start_o) begin
                busyQ <= 1'b1;
                curKindQ <= cycleKind_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_o) begin
            latAddrQ.word <= reqAddr_i;
            latDataQ <= wrData_i;
        end
    end

    assign curKind_o = curKindQ;
    assign latAddr_o = latAddrQ;
    assign latData_o = latDataQ;
    assign busy_o = busyQ;
    assign done_o = doneQ;

endmodule

// ==== src/addressUnit.sv ====
// PC, I and R registers and address multiplexer
`timescale 1ns/10ps
`include "busCycle_settings.svh"

module addressUnit (
    input  logic                   clk_i,
    input  logic                   rstN_i,
    input  logic                   selPc_i,
    input  logic                   selRefresh_i,
    input  logic                   selReq_i,
    input  logic                   incPc_i,
    input  logic                   incR_i,
    input  logic                   lastState_i,
    input  busCyclePkg::addrWord_u latAddr_i,
    input  logic                   pcLoad_i,
    input  logic [`ADDR_W-1:0]     pcValue_i,
    input  logic                   iLoad_i,
    input  logic [`DATA_W-1:0]     iValue_i,
    output logic [`ADDR_W-1:0]     addr_o
);
    import busCyclePkg::*;

    logic [`ADDR_W-1:0] pcReg;
    logic [`DATA_W-1:0] iReg;
    logic [`DATA_W-1:0] rReg;
    addrWord_u addrMux;

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            pcReg <= `PC_RESET;
            iReg <= '0;
            rReg <= '0;
        end else begin
            if (pcLoad_i) begin
                pcReg <= pcValue_i;
            end else if (incPc_i && lastState_i) begin
                pcReg <= pcReg + 1'b1;
            end
            if (iLoad_i) begin
                iReg <= iValue_i;
            end
            if (incR_i && lastState_i) begin
                rReg <= {rReg[`DATA_W-1:`REFRESH_BITS],
                         rReg[`REFRESH_BITS-1:0] + 1'b1}; // bit 7 kept
            end
        end
    end

    always_comb begin
        addrMux.word = '0; // idle bus
        if (selPc_i) begin
            addrMux.word = pcReg;
        end else if (selReq_i) begin
            addrMux.word = latAddr_i.word;
        end else if (selRefresh_i) begin
            addrMux.bytes.hi = iReg;
            addrMux.bytes.lo = rReg;
        end
    end

    assign addr_o = addrMux.word;

endmodule

// ==== src/busPort.sv ====
// registered active-low strobes, write data and read capture
`timescale 1ns/10ps
`include "busCycle_settings.svh"

module busPort (
    input  logic               clk_i,
    input  logic               rstN_i,
    input  logic               m1_i,
    input  logic               mreq_i,
    input  logic               iorq_i,
    input  logic               rd_i,
    input  logic               wr_i,
    input  logic               rfsh_i,
    input  logic               dataOe_i,
    input  logic               capture_i,
    input  logic [`DATA_W-1:0] latData_i,
    input  logic [`DATA_W-1:0] rdBus_i,
    output logic               m1N_o,
    output logic               mreqN_o,
    output logic               iorqN_o,
    output logic               rdN_o,
    output logic               wrN_o,
    output logic               rfshN_o,
    output logic [`DATA_W-1:0] wrBus_o,
    output logic               dataOe_o,
    output logic [`DATA_W-1:0] rdData_o
);

    logic [5:0] strobeNQ; // m1 mreq iorq rd wr rfsh
    logic dataOeQ;
    logic [`DATA_W-1:0] wrBusQ;
    logic [`DATA_W-1:0] rdDataQ;

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            strobeNQ <= '1;
            dataOeQ <= 1'b0;
        end else begin
            strobeNQ <= ~{m1_i, mreq_i, iorq_i, rd_i, wr_i, rfsh_i};
            dataOeQ <= dataOe_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dataOe_i) begin
            wrBusQ <= latData_i; // aligned with dataOe_o
        end
        if (capture_i) begin
            rdDataQ <= rdBus_i;
        end
    end

    assign {m1N_o, mreqN_o, iorqN_o, rdN_o, wrN_o, rfshN_o} = strobeNQ;
    assign dataOe_o = dataOeQ;
    assign wrBus_o = wrBusQ;
    assign rdData_o = rdDataQ;

endmodule

// ==== src/busCycleUnit.sv ====
// bus-cycle controller top level
`timescale 1ns/10ps
`include "busCycle_settings.svh"

module busCycleUnit (
    input  logic                     clk_i,
    input  logic                     rstN_i,
    input  logic                     startStrobe_i,
    input  busCyclePkg::cycleKind_e  cycleKind_i,
    input  logic [`ADDR_W-1:0]       reqAddr_i,
    input  logic [`DATA_W-1:0]       wrData_i,
    input  logic                     waitN_i,
    input  logic [`DATA_W-1:0]       rdBus_i,
    input  logic                     pcLoad_i,
    input  logic [`ADDR_W-1:0]       pcValue_i,
    input  logic                     iLoad_i,
    input  logic [`DATA_W-1:0]       iValue_i,
    output logic [`ADDR_W-1:0]       addr_o,
    output logic [`DATA_W-1:0]       wrBus_o,
    output logic                     dataOe_o,
    output logic                     m1N_o,
    output logic                     mreqN_o,
    output logic                     iorqN_o,
    output logic                     rdN_o,
    output logic                     wrN_o,
    output logic                     rfshN_o,
    output logic                     busy_o,
    output logic                     done_o,
    output logic [`DATA_W-1:0]       rdData_o
);
    import busCyclePkg::*;

    logic start;
    cycleKind_e curKind;
    addrWord_u latAddr;
    logic [`DATA_W-1:0] latData;
    tState_e tState;
    logic enterWait;
    logic holdWait;
    logic lastState;
    logic selPc;
    logic selRefresh;
    logic selReq;
    logic incPc;
    logic incR;
    logic m1;
    logic mreq;
    logic iorq;
    logic rd;
    logic wr;
    logic rfsh;
    logic dataOe;
    logic capture;

    cycleSequencer sequencer (
        .clk_i(clk_i),
        .rstN_i(rstN_i),
        .startStrobe_i(startStrobe_i),
        .cycleKind_i(cycleKind_i),
        .reqAddr_i(reqAddr_i),
        .wrData_i(wrData_i),
        .lastState_i(lastState),
        .start_o(start),
        .curKind_o(curKind),
        .latAddr_o(latAddr),
        .latData_o(latData),
        .busy_o(busy_o),
        .done_o(done_o)
    );

    tStateCounter counter (
        .clk_i(clk_i),
        .rstN_i(rstN_i),
        .start_i(start),
        .enterWait_i(enterWait),
        .holdWait_i(holdWait),
        .lastState_i(lastState),
        .tState_o(tState)
    );

    cycleDecoder decoder (
        .clk_i(clk_i),
        .rstN_i(rstN_i),
        .curKind_i(curKind),
        .tState_i(tState),
        .waitN_i(waitN_i),
        .enterWait_o(enterWait),
        .holdWait_o(holdWait),
        .lastState_o(lastState),
        .selPc_o(selPc),
        .selRefresh_o(selRefresh),
        .selReq_o(selReq),
        .incPc_o(incPc),
        .incR_o(incR),
        .m1_o(m1),
        .mreq_o(mreq),
        .iorq_o(iorq),
        .rd_o(rd),
        .wr_o(wr),
        .rfsh_o(rfsh),
        .dataOe_o(dataOe),
        .capture_o(capture)
    );

    addressUnit address (
        .clk_i(clk_i),
        .rstN_i(rstN_i),
        .selPc_i(selPc),
        .selRefresh_i(selRefresh),
        .selReq_i(selReq),
        .incPc_i(incPc),
        .incR_i(incR),
        .lastState_i(lastState),
        .latAddr_i(latAddr),
        .pcLoad_i(pcLoad_i),
        .pcValue_i(pcValue_i),
        .iLoad_i(iLoad_i),
        .iValue_i(iValue_i),
        .addr_o(addr_o)
    );

    busPort port (
        .clk_i(clk_i),
        .rstN_i(rstN_i),
        .m1_i(m1),
        .mreq_i(mreq),
        .iorq_i(iorq),
        .rd_i(rd),
        .wr_i(wr),
        .rfsh_i(rfsh),
        .dataOe_i(dataOe),
        .capture_i(capture),
        .latData_i(latData),
        .rdBus_i(rdBus_i),
        .m1N_o(m1N_o),
        .mreqN_o(mreqN_o),
        .iorqN_o(iorqN_o),
        .rdN_o(rdN_o),
        .wrN_o(wrN_o),
        .rfshN_o(rfshN_o),
        .wrBus_o(wrBus_o),
        .dataOe_o(dataOe_o),
        .rdData_o(rdData_o)
    );

endmodule

// ==== test/busCycleUnit_tb.sv ====
// testbench with clock, reset, LFSR request stimulus, reference model and bus assertions
`timescale 1ns/10ps
`include "busCycle_settings.svh"

module busCycleUnit_tb;
    import busCyclePkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int MAX_REQS = 40;
    localparam int CYCLE_LIMIT = MAX_REQS * 12 + RESET_CYCLES;

    // model T-state labels
    localparam int ST_IDLE = 0;
    localparam int ST_T1 = 1;
    localparam int ST_T2 = 2;
    localparam int ST_TW = 3;
    localparam int ST_T3 = 4;
    localparam int ST_T4 = 5;

    logic clk;
    logic rstN;
    logic startStrobe;
    cycleKind_e cycleKind;
    logic [`ADDR_W-1:0] reqAddr;
    logic [`DATA_W-1:0] wrData;
    logic waitN;
    logic [`DATA_W-1:0] rdBus;
    logic pcLoad;
    logic [`ADDR_W-1:0] pcValue;
    logic iLoad;
    logic [`DATA_W-1:0] iValue;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wrBus;
    logic dataOe;
    logic m1N;
    logic mreqN;
    logic iorqN;
    logic rdN;
    logic wrN;
    logic rfshN;
    logic busy;
    logic done;
    logic [`DATA_W-1:0] rdData;

    logic [31:0] lfsrState;
    int cycleCount;
    int reqCount;
    string testName;
    logic [5:0] expStrobeN; // m1 mreq iorq rd wr rfsh
    logic expOe;
    logic expBusy;
    logic expDone;
    logic expAddrValid;
    logic expRead;
    logic [15:0] expAddr;
    logic [7:0] expRdData;
    logic [7:0] expWrData;
    logic [15:0] pcM;
    logic [15:0] reqM;
    logic [7:0] iM;
    logic [7:0] rM;
    cycleKind_e curKind;
    cycleKind_e prevKind;
    int prevSt;

    busCycleUnit DUT (
        .clk_i(clk), .rstN_i(rstN),
        .startStrobe_i(startStrobe), .cycleKind_i(cycleKind),
        .reqAddr_i(reqAddr), .wrData_i(wrData), .waitN_i(waitN), .rdBus_i(rdBus),
        .pcLoad_i(pcLoad), .pcValue_i(pcValue), .iLoad_i(iLoad), .iValue_i(iValue),
        .addr_o(addr), .wrBus_o(wrBus), .dataOe_o(dataOe),
        .m1N_o(m1N), .mreqN_o(mreqN), .iorqN_o(iorqN), .rdN_o(rdN), .wrN_o(wrN),
        .rfshN_o(rfshN), .busy_o(busy), .done_o(done), .rdData_o(rdData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic reportMismatch(input string what, input logic [15:0] expV,
                                  input logic [15:0] actV);
        $display("** Error [%s] %s: expected %h, actual %h", testName, what, expV, actV);
        abortRun();
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycleCount);
            abortRun();
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic fb;
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic cycleKind_e pickKind(input logic [2:0] r);
        case (r)
            3'd0, 3'd5: return kFetch;
            3'd1, 3'd6: return kMemRd;
            3'd2, 3'd7: return kMemWr;
            3'd3: return kIoRd;
            default: return kIoWr;
        endcase
    endfunction

    // active-high {m1 mreq iorq rd wr rfsh oe} decoded for one T-state
    function automatic logic [6:0] busStrobes(input cycleKind_e kd, input int s);
        logic [6:0] v;
        logic opHalf;
        logic mid;
        v = '0;
        opHalf = (s == ST_T1) || (s == ST_T2) || (s == ST_TW);
        mid = (s == ST_T2) || (s == ST_TW);
        case (kd)
            kFetch: begin
                if (opHalf) begin
                    v = 7'b1101000;
                end else if (s == ST_T3 || s == ST_T4) begin
                    v = 7'b0100010; // refresh half
                end
            end
            kMemRd: v = opHalf ? 7'b0101000 : 7'b0;
            kMemWr: begin
                v[5] = opHalf || s == ST_T3;
                v[2] = mid;
                v[0] = mid || s == ST_T3;
            end
            kIoRd: begin
                v[4] = mid || s == ST_T3;
                v[3] = mid || s == ST_T3;
            end
            default: begin
                v[4] = mid || s == ST_T3;
                v[2] = mid || s == ST_T3;
                v[0] = mid || s == ST_T3;
            end
        endcase
        return v;
    endfunction

    // waits for the next cycle and sets what the bus must show in it
    task automatic nextCycle(input int s, input logic doneNow);
        logic [6:0] v;
        @(posedge clk);
        v = busStrobes(prevKind, prevSt); // strobes lag one cycle
        expStrobeN = ~v[6:1];
        expOe = v[0];
        expBusy = (s != ST_IDLE);
        expDone = doneNow;
        expAddrValid = (s != ST_IDLE);
        if (curKind == kFetch) begin
            expAddr = (s == ST_T3 || s == ST_T4) ? {iM, rM} : pcM;
        end else begin
            expAddr = reqM;
        end
        prevSt = s;
        prevKind = curKind;
    endtask

    task automatic loadPcAndI(input logic [15:0] pcV, input logic [7:0] iV);
        testName = "pc and i load";
        pcLoad <= 1'b1;
        pcValue <= pcV;
        iLoad <= 1'b1;
        iValue <= iV;
        nextCycle(ST_IDLE, 1'b0);
        pcLoad <= 1'b0;
        iLoad <= 1'b0;
        pcM = pcV;
        iM = iV;
    endtask

    // issues one request from an idle or done cycle and follows it to done
    task automatic runCycle(input cycleKind_e kd, input logic [15:0] a, input logic [7:0] d,
                            input int nWait, input logic pokeBusy);
        int seq[$];
        logic [7:0] rdByte;
        int c;
        rdByte = 8'(randBits(8));
        reqCount++;
        testName = $sformatf("req%0d %s wait%0d", reqCount, kd.name(), nWait);
        seq = {ST_T1, ST_T2};
        repeat (nWait) seq.push_back(ST_TW);
        if (kd == kIoRd || kd == kIoWr) begin
            seq.push_back(ST_TW); // automatic I/O wait
        end
        seq.push_back(ST_T3);
        if (kd == kFetch) begin
            seq.push_back(ST_T4);
        end
        startStrobe <= 1'b1;
        cycleKind <= kd;
        reqAddr <= a;
        wrData <= d;
        rdBus <= ~rdByte; // wrong byte outside the capture state
        curKind = kd;
        reqM = a;
        for (c = 1; c <= seq.size(); c++) begin
            nextCycle(seq[c-1], 1'b0);
            if (c < seq.size() && seq[c] == ST_T3) begin
                rdBus <= rdByte; // sampled at the end of T2 or the last Tw
            end else begin
                rdBus <= ~rdByte;
            end
            if (c == 1) begin
                startStrobe <= 1'b0;
                expWrData = d;
            end
            if (pokeBusy && c == 2) begin
                startStrobe <= 1'b1; // busy, must be dropped
                reqAddr <= ~a;
            end
            if (pokeBusy && c == 3) begin
                startStrobe <= 1'b0;
            end
            if (c == 2 && nWait > 0) begin
                waitN <= 1'b0;
            end
            if (c == nWait + 2) begin
                waitN <= 1'b1;
            end
        end
        expRead = (kd == kFetch || kd == kMemRd || kd == kIoRd);
        expRdData = rdByte;
        nextCycle(ST_IDLE, 1'b1);
        if (kd == kFetch) begin
            pcM = pcM + 16'd1;
            rM = {rM[7], rM[6:0] + 7'd1}; // bit 7 held
        end
    endtask

    assert property (@(negedge clk) disable iff (!rstN)
        {m1N, mreqN, iorqN, rdN, wrN, rfshN} == expStrobeN)
        else reportMismatch("strobes", 16'(expStrobeN), 16'({m1N, mreqN, iorqN, rdN, wrN, rfshN}));
    assert property (@(negedge clk) disable iff (!rstN) dataOe == expOe)
        else reportMismatch("dataOe", 16'(expOe), 16'(dataOe));
    assert property (@(negedge clk) disable iff (!rstN) busy == expBusy)
        else reportMismatch("busy", 16'(expBusy), 16'(busy));
    assert property (@(negedge clk) disable iff (!rstN) done == expDone)
        else reportMismatch("done", 16'(expDone), 16'(done));
    assert property (@(negedge clk) disable iff (!rstN) !expAddrValid || addr == expAddr)
        else reportMismatch("addr", expAddr, addr);
    assert property (@(negedge clk) disable iff (!rstN) !(expDone && expRead) || rdData == expRdData)
        else reportMismatch("rdData", 16'(expRdData), 16'(rdData));
    assert property (@(negedge clk) disable iff (!rstN) !dataOe || wrBus == expWrData)
        else reportMismatch("wrBus", 16'(expWrData), 16'(wrBus));

    initial begin : stimulus
        cycleKind_e kd;
        logic [15:0] a;
        logic [7:0] d;
        int nWait;
        logic poke;
        rstN = 1'b0;
        startStrobe = 1'b0;
        cycleKind = kFetch;
        reqAddr = '0;
        wrData = '0;
        waitN = 1'b1;
        rdBus = '0;
        pcLoad = 1'b0;
        pcValue = '0;
        iLoad = 1'b0;
        iValue = '0;
        lfsrState = 32'hf33ccbe2;
        cycleCount = 0;
        reqCount = 0;
        testName = "reset";
        expStrobeN = '1;
        expOe = 1'b0;
        expBusy = 1'b0;
        expDone = 1'b0;
        expAddrValid = 1'b0;
        expRead = 1'b0;
        expAddr = '0;
        expRdData = '0;
        expWrData = '0;
        pcM = 16'h0000;
        reqM = '0;
        iM = '0;
        rM = '0;
        curKind = kFetch;
        prevKind = kFetch;
        prevSt = ST_IDLE;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        nextCycle(ST_IDLE, 1'b0);
        nextCycle(ST_IDLE, 1'b0);
        runCycle(kFetch, 16'h0000, 8'h00, 0, 1'b0); // first fetch from 0000h
        runCycle(kFetch, 16'h0000, 8'h00, 1, 1'b0);
        loadPcAndI(16'h8a31, 8'h5c);
        runCycle(kFetch, 16'h0000, 8'h00, 2, 1'b1);
        runCycle(kMemRd, 16'h4321, 8'h00, 0, 1'b0);
        runCycle(kMemWr, 16'h1234, 8'ha5, 0, 1'b0);
        runCycle(kIoRd, 16'h00fe, 8'h00, 0, 1'b0);
        runCycle(kIoWr, 16'h0077, 8'h3c, 0, 1'b0);
        while (reqCount < MAX_REQS) begin
            kd = pickKind(3'(randBits(3)));
            a = 16'(randBits(16));
            d = 8'(randBits(8));
            nWait = randBits(2);
            poke = 1'(randBits(1));
            if (randBits(1)) begin
                nextCycle(ST_IDLE, 1'b0); // else back to back
            end
            runCycle(kd, a, d, nWait, poke);
        end
        nextCycle(ST_IDLE, 1'b0);
        nextCycle(ST_IDLE, 1'b0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== busCycleUnit.f ====
+incdir+common
common/busCyclePkg.sv
cycleDecoder/fetchDecode.sv
cycleDecoder/transferDecode.sv
cycleDecoder/cycleDecoder.sv
src/tStateCounter.sv
src/cycleSequencer.sv
src/addressUnit.sv
src/busPort.sv
src/busCycleUnit.sv
test/busCycleUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module busCycleUnit_tb \
    -f busCycleUnit.f -o busCycleUnit_sim &&
./obj_dir/busCycleUnit_sim || exit 1
